// ==== lane_top.f ====
+incdir+src
src/lane_pkg.sv
src/operand_requester.sv
src/vector_regfile.sv
src/operand_queue.sv
src/lane_alu.sv
src/lane_top.sv
dv/lane_chk.sv
dv/tb_lane_top.sv

// ==== Makefile ====
# Verilator flow for the vector lane testbench, run from the project root

VERILATOR ?= verilator
TOP       ?= tb_lane_top
FILELIST  ?= lane_top.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
BFLAGS    ?= -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Finished with no errors

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) $(BFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BIN)
	./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/lane_vectors.txt ====
// P addr data = load write, I op sew vd vs1 vs2 vl = instruction (all fields hex)
// E addr data = expected result, listed in element order after its instruction
P 08 ffffffffffffffff
P 09 00000000ffffffff
P 10 0000000000000001
P 11 0000000100000001
I 0 0 03 01 02 2
E 18 0000000000000000
E 19 0000000200000000
I 4 0 08 03 01 2
E 40 ffffffffffffffff
E 41 00000002ffffffff
I 0 1 04 01 02 2
E 20 ffffffff00000000
E 21 0000000100000000
I 1 0 05 02 01 1
E 28 0000000000000002
I 1 1 06 02 01 1
E 30 0000000100000002
I 2 0 07 01 02 1
E 38 0000000000000001
I 3 1 09 02 03 2
E 48 0000000000000001
E 49 0000000300000001

// ==== dv/tb_lane_top.sv ====
// Must run from the project root so dv/lane_vectors.txt is found; one instruction in flight
`timescale 1ns/1ps
`include "lane_defines.svh"

module tb_lane_top;

  import lane_pkg::*;

  localparam int clk_half_ns     = 4;
  localparam int clk_period_ns   = 2 * clk_half_ns;
  localparam int cycles_per_line = 40;

  logic    clk_i;
  logic    rst_ni;
  pe_req_t pe_req_i;
  logic    pe_req_valid_i;
  logic    pe_req_ready_o;
  logic    ldu_req_i;
  wr_req_t ldu_wr_i;
  logic    ldu_gnt_o;
  wr_req_t result_o;
  logic    result_valid_o;
  logic    vinsn_done_o;

  vaddr_t                pre_addr[$];
  logic [`LANE_ELEN-1:0] pre_data[$];
  pe_req_t               insns[$];
  vaddr_t                exp_addr[$];
  logic [`LANE_ELEN-1:0] exp_data[$];
  logic                  exp_last[$];

  int n_vec       = 0;
  int exp_idx     = 0;
  int done_cnt    = 0;
  int held_cycles = 0;
  int result_errs = 0;
  int flow_errs   = 0;
  bit file_ok     = 1'b0;
  bit loaded      = 1'b0;
  bit timed_out   = 1'b0;

  lane_top lane_top_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pe_req_i      (pe_req_i),
    .pe_req_valid_i(pe_req_valid_i),
    .pe_req_ready_o(pe_req_ready_o),
    .ldu_req_i     (ldu_req_i),
    .ldu_wr_i      (ldu_wr_i),
    .ldu_gnt_o     (ldu_gnt_o),
    .result_o      (result_o),
    .result_valid_o(result_valid_o),
    .vinsn_done_o  (vinsn_done_o)
  );

  bind lane_top lane_chk lane_chk_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pe_req_valid_i(pe_req_valid_i),
    .pe_req_ready_o(pe_req_ready_o),
    .ldu_gnt_o     (ldu_gnt_o),
    .result_valid_o(result_valid_o),
    .vinsn_done_o  (vinsn_done_o)
  );

  always #(clk_half_ns) clk_i = ~clk_i;

  ////////////////////
  // Vector file
  ////////////////////

  task automatic load_vectors(output bit ok);
    int                    fd;
    int                    fields;
    string                 line;
    string                 rest;
    byte                   kind;
    logic [31:0]           f_addr;
    logic [31:0]           f_op;
    logic [31:0]           f_sew;
    logic [31:0]           f_vd;
    logic [31:0]           f_vs1;
    logic [31:0]           f_vs2;
    logic [31:0]           f_vl;
    logic [`LANE_ELEN-1:0] f_data;
    pe_req_t               req;
    ok = 1'b0;
    fd = $fopen("dv/lane_vectors.txt", "r");
    if (fd == 0) begin
      return;
    end
    ok = 1'b1;
    while ($fgets(line, fd) != 0) begin
      kind = line.getc(0);
      rest = line.substr(1, line.len() - 1);
      if (kind == "P" || kind == "E") begin
        fields = $sscanf(rest, "%h %h", f_addr, f_data);
        if (fields != 2) begin
          ok = 1'b0;
        end
        if (kind == "P") begin
          pre_addr.push_back(vaddr_t'(f_addr));
          pre_data.push_back(f_data);
        end else begin
          exp_addr.push_back(vaddr_t'(f_addr));
          exp_data.push_back(f_data);
          exp_last.push_back(1'b0);
        end
        n_vec++;
      end else if (kind == "I") begin
        fields = $sscanf(rest, "%h %h %h %h %h %h", f_op, f_sew, f_vd, f_vs1, f_vs2, f_vl);
        if (fields != 6) begin
          ok = 1'b0;
        end
        // The previous instruction ends at its final expected line
        if (exp_last.size() > 0) begin
          exp_last[exp_last.size() - 1] = 1'b1;
        end
        req.op  = alu_op_e'(f_op[2:0]);
        req.sew = sew_e'(f_sew[0]);
        req.vd  = f_vd[4:0];
        req.vs1 = f_vs1[4:0];
        req.vs2 = f_vs2[4:0];
        req.vl  = f_vl[3:0];
        insns.push_back(req);
        n_vec++;
      end
    end
    if (exp_last.size() > 0) begin
      exp_last[exp_last.size() - 1] = 1'b1;
    end
    $fclose(fd);
  endtask

  ////////////////////
  // Drivers
  ////////////////////

  // Starts on a falling edge and holds the load request until the grant is seen
  task automatic load_write(input vaddr_t addr, input logic [`LANE_ELEN-1:0] data,
                            output int waits);
    waits         = 0;
    ldu_req_i     = 1'b1;
    ldu_wr_i.addr = addr;
    ldu_wr_i.data = data;
    #1;
    while (!ldu_gnt_o) begin
      waits++;
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    ldu_req_i = 1'b0;
  endtask

  // Same preload again while the ALU writes back, so the grant has to wait
  task automatic load_during_writeback(input vaddr_t addr, input logic [`LANE_ELEN-1:0] data);
    int waits;
    @(negedge clk_i);
    while (!result_valid_o) begin
      @(negedge clk_i);
    end
    load_write(addr, data, waits);
    if (waits == 0) begin
      $display("Load write was granted in a cycle with an ALU write-back");
      flow_errs++;
    end
  endtask

  task automatic send_insn(input pe_req_t req);
    @(negedge clk_i);
    pe_req_valid_i = 1'b1;
    pe_req_i       = req;
    #1;
    while (!pe_req_ready_o) begin
      held_cycles++;
      @(negedge clk_i);
      #1;
    end
    // Accepted on this edge
    @(posedge clk_i);
  endtask

  task automatic close_run();
    int chk_fails;
    chk_fails = lane_top_inst.lane_chk_inst.gnt_fails + lane_top_inst.lane_chk_inst.done_fails
              + lane_top_inst.lane_chk_inst.hold_fails
              + lane_top_inst.lane_chk_inst.release_fails;
    $display("Errors: %0d result, %0d flow, %0d assertion, timeout %0d",
             result_errs, flow_errs, chk_fails, timed_out);
    if (result_errs == 0 && flow_errs == 0 && chk_fails == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (vinsn_done_o) begin
        done_cnt++;
      end
      if (result_valid_o) begin
        if (exp_idx >= exp_addr.size()) begin
          $display("Unexpected result at address %h beyond the expected list", result_o.addr);
          result_errs++;
        end else begin
          if (result_o.addr !== exp_addr[exp_idx]) begin
            $display("** Error: result_o.addr got %h expected %h",
                     result_o.addr, exp_addr[exp_idx]);
            result_errs++;
          end
          if (result_o.data !== exp_data[exp_idx]) begin
            $display("** Error: result_o.data at %h got %h expected %h",
                     exp_addr[exp_idx], result_o.data, exp_data[exp_idx]);
            result_errs++;
          end
          if (vinsn_done_o !== exp_last[exp_idx]) begin
            $display("** Error: vinsn_done_o at %h got %h expected %h",
                     exp_addr[exp_idx], vinsn_done_o, exp_last[exp_idx]);
            result_errs++;
          end
          exp_idx++;
        end
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    #(n_vec * cycles_per_line * clk_period_ns);
    $display("Timeout after %0d cycles, %0d of %0d results seen",
             n_vec * cycles_per_line, exp_idx, exp_addr.size());
    timed_out = 1'b1;
    close_run();
  end

  initial begin : main
    int load_waits;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    pe_req_i       = '0;
    pe_req_valid_i = 1'b0;
    ldu_req_i      = 1'b0;
    ldu_wr_i       = '0;
    load_vectors(file_ok);
    if (!file_ok) begin
      $display("Could not open or parse dv/lane_vectors.txt");
      flow_errs++;
      close_run();
    end else begin
      loaded = 1'b1;
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      for (int i = 0; i < pre_addr.size(); i++) begin
        load_write(pre_addr[i], pre_data[i], load_waits);
      end
      fork
        begin
          // Next request goes out right after acceptance, while the lane is busy
          for (int i = 0; i < insns.size(); i++) begin
            send_insn(insns[i]);
          end
          @(negedge clk_i);
          pe_req_valid_i = 1'b0;
        end
        begin
          if (pre_addr.size() > 0 && insns.size() > 0) begin
            load_during_writeback(pre_addr[0], pre_data[0]);
          end
        end
      join
      wait (exp_idx == exp_addr.size());
      repeat (4) @(negedge clk_i);
      if (!pe_req_ready_o) begin
        $display("Lane did not return to ready after the last instruction");
        flow_errs++;
      end
      if (done_cnt != insns.size()) begin
        $display("Saw %0d done pulses for %0d instructions", done_cnt, insns.size());
        flow_errs++;
      end
      if (insns.size() > 1 && held_cycles == 0) begin
        $display("No request was ever held off while the lane was busy");
        flow_errs++;
      end
      close_run();
    end
  end

endmodule

// ==== dv/lane_chk.sv ====
// Handshake checks on the lane ports only; assumes one instruction in flight at a time
`timescale 1ns/1ps

module lane_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic pe_req_valid_i,
  input logic pe_req_ready_o,
  input logic ldu_gnt_o,
  input logic result_valid_o,
  input logic vinsn_done_o
);

  int unsigned gnt_fails     = 0;
  int unsigned done_fails    = 0;
  int unsigned hold_fails    = 0;
  int unsigned release_fails = 0;

  // ALU write-back owns the port, so no grant beside a result
  assert property (@(posedge clk_i) disable iff (!rst_ni) ldu_gnt_o |-> !result_valid_o)
    else begin
      $error("ldu_gnt_o high in a cycle with result_valid_o");
      gnt_fails = gnt_fails + 1;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) vinsn_done_o |-> result_valid_o)
    else begin
      $error("vinsn_done_o without result_valid_o");
      done_fails = done_fails + 1;
    end

  // Busy from acceptance until the done pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   ((pe_req_valid_i && pe_req_ready_o) || (!pe_req_ready_o && !vinsn_done_o))
                   |=> !pe_req_ready_o)
    else begin
      $error("pe_req_ready_o rose before the done pulse");
      hold_fails = hold_fails + 1;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) vinsn_done_o |=> pe_req_ready_o)
    else begin
      $error("pe_req_ready_o not high the cycle after vinsn_done_o");
      release_fails = release_fails + 1;
    end

endmodule

// ==== src/lane_top.sv ====
// Single integer lane; load writes must be held by the requester until ldu_gnt_o is seen
`timescale 1ns/1ps

module lane_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  lane_pkg::pe_req_t pe_req_i,
  input  logic              pe_req_valid_i,
  output logic              pe_req_ready_o,
  input  logic              ldu_req_i,
  input  lane_pkg::wr_req_t ldu_wr_i,
  output logic              ldu_gnt_o,
  output lane_pkg::wr_req_t result_o,
  output logic              result_valid_o,
  output logic              vinsn_done_o
);

  import lane_pkg::*;

  logic       rd_en;
  vaddr_t     rd_addr_a;
  vaddr_t     rd_addr_b;
  elen_u      rd_data_a;
  elen_u      rd_data_b;
  logic       push;
  opq_entry_t req_meta;
  opq_entry_t opq_push_entry;
  opq_entry_t opq_head;
  logic       opq_not_empty;
  logic       opq_pop;
  logic       alu_wr_valid;
  wr_req_t    alu_wr;
  logic       alu_done;

  operand_requester operand_requester_inst (
    .clk_i         (clk_i         ),
    .rst_ni        (rst_ni        ),
    .pe_req_i      (pe_req_i      ),
    .pe_req_valid_i(pe_req_valid_i),
    .pe_req_ready_o(pe_req_ready_o),
    .rd_en_o       (rd_en         ),
    .rd_addr_a_o   (rd_addr_a     ),
    .rd_addr_b_o   (rd_addr_b     ),
    .push_o        (push          ),
    .push_entry_o  (req_meta      ),
    .pop_i         (opq_pop       ),
    .vinsn_done_i  (alu_done      )
  );

  vector_regfile vector_regfile_inst (
    .clk_i         (clk_i       ),
    .rst_ni        (rst_ni      ),
    .rd_en_i       (rd_en       ),
    .rd_addr_a_i   (rd_addr_a   ),
    .rd_addr_b_i   (rd_addr_b   ),
    .rd_data_a_o   (rd_data_a   ),
    .rd_data_b_o   (rd_data_b   ),
    .alu_wr_valid_i(alu_wr_valid),
    .alu_wr_i      (alu_wr      ),
    .ldu_req_i     (ldu_req_i   ),
    .ldu_wr_i      (ldu_wr_i    ),
    .ldu_gnt_o     (ldu_gnt_o   )
  );

  // Read data joins its metadata on the push
  assign opq_push_entry = '{opa:     rd_data_a,
                            opb:     rd_data_b,
                            op:      req_meta.op,
                            sew:     req_meta.sew,
                            vd_addr: req_meta.vd_addr,
                            last:    req_meta.last};

  operand_queue operand_queue_inst (
    .clk_i       (clk_i         ),
    .rst_ni      (rst_ni        ),
    .push_i      (push          ),
    .push_entry_i(opq_push_entry),
    .pop_i       (opq_pop       ),
    .head_o      (opq_head      ),
    .not_empty_o (opq_not_empty )
  );

  lane_alu lane_alu_inst (
    .clk_i       (clk_i        ),
    .rst_ni      (rst_ni       ),
    .head_i      (opq_head     ),
    .not_empty_i (opq_not_empty),
    .pop_o       (opq_pop      ),
    .wr_valid_o  (alu_wr_valid ),
    .wr_o        (alu_wr       ),
    .vinsn_done_o(alu_done     )
  );

  assign result_o       = alu_wr;
  assign result_valid_o = alu_wr_valid;
  assign vinsn_done_o   = alu_done;

endmodule

// ==== src/lane_alu.sv ====
// Integer ops only, no masking or saturation; SEW32 halves never pass a carry to each other
`timescale 1ns/1ps
`include "lane_defines.svh"

module lane_alu (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lane_pkg::opq_entry_t head_i,
  input  logic                 not_empty_i,
  output logic                 pop_o,
  output logic                 wr_valid_o,
  output lane_pkg::wr_req_t    wr_o,
  output logic                 vinsn_done_o
);

  import lane_pkg::*;

  elen_u   res;
  wr_req_t wr_q;
  logic    wr_valid_q;
  logic    done_q;

  function automatic logic [`LANE_ELEN-1:0] alu_calc(alu_op_e op, logic [`LANE_ELEN-1:0] a,
                                                     logic [`LANE_ELEN-1:0] b);
    logic [`LANE_ELEN-1:0] r;
    unique case (op)
      ALU_ADD: r = a + b;
      ALU_SUB: r = a - b;
      ALU_AND: r = a & b;
      ALU_OR:  r = a | b;
      ALU_XOR: r = a ^ b;
      default: r = '0;
    endcase
    return r;
  endfunction

  // Never stalls, so every waiting entry goes out
  assign pop_o = not_empty_i;

  ////////////////////
  // Datapath
  ////////////////////

  always_comb begin
    logic [`LANE_ELEN-1:0] half;
    res  = '0;
    half = '0;
    if (head_i.sew == SEW64) begin
      res.w64 = alu_calc(head_i.op, head_i.opa.w64, head_i.opb.w64);
    end else begin
      // Zero-extended halves, upper bits dropped
      for (int i = 0; i < 2; i++) begin
        half = alu_calc(head_i.op, {{(`LANE_ELEN/2){1'b0}}, head_i.opa.w32[i]},
                        {{(`LANE_ELEN/2){1'b0}}, head_i.opb.w32[i]});
        res.w32[i] = half[`LANE_ELEN/2-1:0];
      end
    end
  end

  ////////////////////
  // Write-back
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_valid_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      wr_valid_q <= pop_o;
      done_q     <= pop_o && head_i.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      wr_q.addr <= head_i.vd_addr;
      wr_q.data <= res.w64;
    end
  end

  assign wr_valid_o   = wr_valid_q;
  assign wr_o         = wr_q;
  // Same cycle as the last element's write
  assign vinsn_done_o = done_q;

endmodule

// ==== src/operand_queue.sv ====
// No overflow guard here; the requester's credit count keeps pushes within the free entries
`timescale 1ns/1ps
`include "lane_defines.svh"

module operand_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 push_i,
  input  lane_pkg::opq_entry_t push_entry_i,
  input  logic                 pop_i,
  output lane_pkg::opq_entry_t head_o,
  output logic                 not_empty_o
);

  import lane_pkg::*;

  localparam int unsigned PtrW = $clog2(`LANE_OPQ_DEPTH);
  localparam int unsigned CntW = $clog2(`LANE_OPQ_DEPTH + 1);

  opq_entry_t       entries [`LANE_OPQ_DEPTH];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             do_pop;

  assign not_empty_o = (count_q != '0);
  assign do_pop      = pop_i && not_empty_o;
  assign head_o      = entries[rd_ptr_q];

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entries[wr_ptr_q] <= push_entry_i;
    end
  end

  // Pointers wrap at the depth, which is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + PtrW'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + PtrW'(1);
      end
      unique case ({push_i, do_pop})
        2'b10:   count_q <= count_q + CntW'(1);
        2'b01:   count_q <= count_q - CntW'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== src/vector_regfile.sv ====
// Single write port shared by ALU and load unit; the ALU always wins, memory contents are not reset
`timescale 1ns/1ps
`include "lane_defines.svh"

module vector_regfile (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rd_en_i,
  input  lane_pkg::vaddr_t  rd_addr_a_i,
  input  lane_pkg::vaddr_t  rd_addr_b_i,
  output lane_pkg::elen_u   rd_data_a_o,
  output lane_pkg::elen_u   rd_data_b_o,
  input  logic              alu_wr_valid_i,
  input  lane_pkg::wr_req_t alu_wr_i,
  input  logic              ldu_req_i,
  input  lane_pkg::wr_req_t ldu_wr_i,
  output logic              ldu_gnt_o
);

  import lane_pkg::*;

  localparam int unsigned Words = `LANE_NR_VREGS * `LANE_ELEMS;

  logic [`LANE_ELEN-1:0] mem [Words];
  elen_u                 rd_a_q;
  elen_u                 rd_b_q;
  logic                  wr_en;
  wr_req_t               wr;

  ////////////////////
  // Write arbitration
  ////////////////////

  // Load unit only gets the port in idle ALU cycles
  assign ldu_gnt_o = ldu_req_i && !alu_wr_valid_i;
  assign wr_en     = alu_wr_valid_i || ldu_gnt_o;
  assign wr        = alu_wr_valid_i ? alu_wr_i : ldu_wr_i;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // Data comes back one cycle after the strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_a_q <= '0;
      rd_b_q <= '0;
    end else if (rd_en_i) begin
      rd_a_q.w64 <= mem[rd_addr_a_i];
      rd_b_q.w64 <= mem[rd_addr_b_i];
    end
  end

  assign rd_data_a_o = rd_a_q;
  assign rd_data_b_o = rd_b_q;

endmodule

// ==== src/operand_requester.sv ====
// One instruction in flight at a time; no hazard check, the next request waits for the done pulse
`timescale 1ns/1ps
`include "lane_defines.svh"

module operand_requester (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lane_pkg::pe_req_t    pe_req_i,
  input  logic                 pe_req_valid_i,
  output logic                 pe_req_ready_o,
  output logic                 rd_en_o,
  output lane_pkg::vaddr_t     rd_addr_a_o,
  output lane_pkg::vaddr_t     rd_addr_b_o,
  output logic                 push_o,
  output lane_pkg::opq_entry_t push_entry_o,
  input  logic                 pop_i,
  input  logic                 vinsn_done_i
);

  import lane_pkg::*;

  localparam int unsigned ElemW = $clog2(`LANE_ELEMS);
  localparam int unsigned CntW  = $clog2(`LANE_OPQ_DEPTH + 1);

  pe_req_t           insn_q;
  logic              busy_q;
  logic              issuing_q;
  logic [ElemW-1:0]  elem_q;
  logic [CntW-1:0]   credits_q;
  logic [CntW-1:0]   credits_d;
  logic              last_elem;
  logic              accept;
  logic              push_q;
  opq_entry_t        meta_q;

  assign pe_req_ready_o = !busy_q;
  assign accept         = pe_req_valid_i && pe_req_ready_o;

  // Element index is the low part of the word address
  assign rd_addr_a_o = {insn_q.vs1, elem_q};
  assign rd_addr_b_o = {insn_q.vs2, elem_q};
  assign rd_en_o     = issuing_q && (credits_q != '0);
  assign last_elem   = ({1'b0, elem_q} == (insn_q.vl - 4'd1));

  ////////////////////
  // Queue credits
  ////////////////////

  // A credit is taken at read issue, one cycle before the push
  always_comb begin
    credits_d = credits_q;
    unique case ({rd_en_o, pop_i})
      2'b10:   credits_d = credits_q - CntW'(1);
      2'b01:   credits_d = credits_q + CntW'(1);
      default: credits_d = credits_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      issuing_q <= 1'b0;
      elem_q    <= '0;
      credits_q <= CntW'(`LANE_OPQ_DEPTH);
      push_q    <= 1'b0;
    end else begin
      credits_q <= credits_d;
      push_q    <= rd_en_o;
      if (accept) begin
        busy_q    <= 1'b1;
        issuing_q <= 1'b1;
        elem_q    <= '0;
      end else begin
        if (vinsn_done_i) begin
          busy_q <= 1'b0;
        end
        if (rd_en_o) begin
          elem_q <= elem_q + ElemW'(1);
          if (last_elem) begin
            issuing_q <= 1'b0;
          end
        end
      end
    end
  end

  // Latched instruction and per-element metadata
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= pe_req_i;
    end
    if (rd_en_o) begin
      meta_q.opa     <= '0;
      meta_q.opb     <= '0;
      meta_q.op      <= insn_q.op;
      meta_q.sew     <= insn_q.sew;
      meta_q.vd_addr <= {insn_q.vd, elem_q};
      meta_q.last    <= last_elem;
    end
  end

  ////////////////////
  // Push to the queue
  ////////////////////

  // Lines up with the registered read data
  assign push_o       = push_q;
  assign push_entry_o = meta_q;

endmodule

// ==== src/lane_pkg.sv ====
// Types only; the struct widths follow lane_defines.svh and the opcode list covers integer ops only
`include "lane_defines.svh"

package lane_pkg;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  typedef enum logic {
    SEW64 = 1'b0,
    SEW32 = 1'b1
  } sew_e;

  // Register index in the upper bits, element index in the lower bits
  typedef logic [`LANE_ADDR_W-1:0] vaddr_t;

  // One element, seen as a full word or as two 32-bit sub-elements
  typedef union packed {
    logic [`LANE_ELEN-1:0]             w64;
    logic [1:0][`LANE_ELEN/2-1:0]      w32;
  } elen_u;

  ////////////////////
  // Bundles
  ////////////////////

  // Instruction from the sequencer, vl counts 1 to 8
  typedef struct packed {
    alu_op_e    op;
    sew_e       sew;
    logic [4:0] vd;
    logic [4:0] vs1;
    logic [4:0] vs2;
    logic [3:0] vl;
  } pe_req_t;

  typedef struct packed {
    elen_u   opa;
    elen_u   opb;
    alu_op_e op;
    sew_e    sew;
    vaddr_t  vd_addr;
    logic    last;
  } opq_entry_t;

  typedef struct packed {
    vaddr_t                addr;
    logic [`LANE_ELEN-1:0] data;
  } wr_req_t;

endpackage

// ==== src/lane_defines.svh ====
// Lane geometry is fixed at 32 registers of 8 elements, so vaddr_t is exactly reg index and element
`ifndef LANE_DEFINES_SVH
`define LANE_DEFINES_SVH

////////////////////
// Register file geometry
////////////////////

// Architectural vector registers held by the lane
`define LANE_NR_VREGS 32

// Elements of one register stored in this lane
`define LANE_ELEMS 8

// Element width in bits
`define LANE_ELEN 64

// Word address into the lane register file
`define LANE_ADDR_W 8

// Entries in the operand queue
`define LANE_OPQ_DEPTH 4

`endif
